/* Makefile */
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module detStage1Top

sim:
	verilator --binary --timing --assert -f files.f --top-module detStage1Tb -o simv
	./obj_dir/simv 2>&1 | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* files.f */
hw/detPkg.sv
hw/metricStreamIf.sv
hw/setupGen.sv
hw/acsOp.sv
hw/acsStage1.sv
hw/survivorSelect.sv
hw/detStage1Top.sv
sim/detStage1_assert.sv
sim/detStage1Tb.sv

/* hw/acsOp.sv */
`timescale 1ns/100ps
`default_nettype none

module acsOp #(
    parameter int METRIC_LAT = 2
) (
    input wire logic clk,
    input wire logic reset,
    input wire logic inEn,
    input wire detPkg::sample_t yReal,
    input wire detPkg::sample_t yImag,
    input wire detPkg::sample_t sReal,
    input wire detPkg::sample_t sImag,
    input wire detPkg::metric_t accIn,
    output logic outEn,
    output detPkg::metric_t accOut
);
    import detPkg::*;

    logic signed [18:0] diffRe;
    logic signed [18:0] diffIm;
    logic [37:0] sqRe;
    logic [37:0] sqIm;
    metric_t accQ;
    logic enQ;
    logic [38:0] distSum;
    logic [23:0] accSum;
    logic delEn [METRIC_LAT-1];
    metric_t delAcc [METRIC_LAT-1];

    assign diffRe = sReal - yReal;
    assign diffIm = sImag - yImag;

    always_ff @(posedge clk) begin
        sqRe <= diffRe * diffRe;
        sqIm <= diffIm * diffIm;
        accQ <= accIn;
    end

    assign distSum = sqRe + sqIm;
    assign accSum = 24'(distSum >> DIST_SHIFT) + 24'(accQ);

    // index 0 is the second stage, the rest is plain delay.
    always_ff @(posedge clk) begin
        delAcc[0] <= (|accSum[23:18]) ? '1 : accSum[17:0];
        for (int i = 1; i < METRIC_LAT - 1; i++) begin
            delAcc[i] <= delAcc[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            enQ <= 1'b0;
            for (int i = 0; i < METRIC_LAT - 1; i++) begin
                delEn[i] <= 1'b0;
            end
        end else begin
            enQ <= inEn;
            delEn[0] <= enQ;
            for (int i = 1; i < METRIC_LAT - 1; i++) begin
                delEn[i] <= delEn[i-1];
            end
        end
    end

    assign outEn = delEn[METRIC_LAT-2];
    assign accOut = delAcc[METRIC_LAT-2];

endmodule

`default_nettype wire

/* hw/acsStage1.sv */
`timescale 1ns/100ps
`default_nettype none

module acsStage1 #(
    parameter int METRIC_LAT = 2
) (
    input wire logic clk,
    input wire logic reset,
    input wire logic clkEn,
    input wire logic startFrame,
    input wire logic startBlock,
    input wire logic startStage,
    input wire detPkg::sample_t in1Real,
    input wire detPkg::sample_t in1Imag,
    input wire logic setupValid,
    input wire detPkg::sample_t setupReal,
    input wire detPkg::sample_t setupImag,
    input wire logic accMetricInEn,
    input wire detPkg::metric_t accMetricIn,
    metricStreamIf.source metOut,
    output logic startNextStage
);
    import detPkg::*;

    sample_t tableReal [NUM_POINTS];
    sample_t tableImag [NUM_POINTS];
    pointIdx_t wrAddr;
    pointIdx_t metricAddr;
    sample_t sampleReal;
    sample_t sampleImag;
    pointIdx_t tagIdx [METRIC_LAT];
    logic tagLast [METRIC_LAT];
    logic outEn;
    metric_t outMetric;

    always_ff @(posedge clk) begin
        if (reset || (clkEn && startFrame)) begin
            wrAddr <= '0;
        end else if (setupValid) begin
            wrAddr <= wrAddr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (setupValid) begin
            tableReal[wrAddr] <= setupReal;
            tableImag[wrAddr] <= setupImag;
        end
    end

    always_ff @(posedge clk) begin
        if (clkEn && startBlock) begin
            sampleReal <= in1Real;
            sampleImag <= in1Imag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || startStage) begin
            metricAddr <= '0;
        end else if (accMetricInEn) begin
            metricAddr <= metricAddr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            startNextStage <= 1'b0;
        end else begin
            startNextStage <= accMetricInEn && (metricAddr == pointIdx_t'(1));   // second metric.
        end
    end

    // tags ride alongside the acsOp pipeline.
    always_ff @(posedge clk) begin
        tagIdx[0] <= metricAddr;
        tagLast[0] <= (metricAddr == pointIdx_t'(NUM_POINTS - 1));
        for (int i = 1; i < METRIC_LAT; i++) begin
            tagIdx[i] <= tagIdx[i-1];
            tagLast[i] <= tagLast[i-1];
        end
    end

    acsOp #(
        .METRIC_LAT(METRIC_LAT)
    ) u_acsOp (
        .clk(clk),
        .reset(reset),
        .inEn(accMetricInEn),
        .yReal(tableReal[metricAddr]),
        .yImag(tableImag[metricAddr]),
        .sReal(sampleReal),
        .sImag(sampleImag),
        .accIn(accMetricIn),
        .outEn(outEn),
        .accOut(outMetric)
    );

    assign metOut.valid = outEn;
    assign metOut.metric = outMetric;
    assign metOut.index = tagIdx[METRIC_LAT-1];
    assign metOut.last = tagLast[METRIC_LAT-1];

endmodule

`default_nettype wire

/* hw/detPkg.sv */
`default_nettype none

package detPkg;

    // signed component of samples, gains and table points.
    typedef logic signed [17:0] sample_t;

    // unsigned path metric.
    typedef logic [17:0] metric_t;

    // hypothesis index, [3:2] real level and [1:0] imaginary level.
    typedef logic [3:0] pointIdx_t;

    localparam int NUM_POINTS = 16;
    localparam int DIST_SHIFT = 16;

    // Gray-free natural mapping of a 2-bit code onto the 16-QAM axis.
    function automatic logic signed [2:0] qamLevel(input logic [1:0] code);
        logic signed [2:0] level;
        case (code)
            2'd0: level = -3'sd3;
            2'd1: level = -3'sd1;
            2'd2: level = 3'sd1;
            default: level = 3'sd3;
        endcase
        return level;
    endfunction

endpackage

`default_nettype wire

/* hw/detStage1Top.sv */
`timescale 1ns/100ps
`default_nettype none

module detStage1Top #(
    parameter int METRIC_LAT = 2
) (
    input wire logic clk,
    input wire logic reset,
    input wire logic clkEn,
    input wire logic startFrame,
    input wire logic startBlock,
    input wire logic startStage,
    input wire logic accMetricInEn,
    input wire detPkg::sample_t gainReal,
    input wire detPkg::sample_t gainImag,
    input wire detPkg::sample_t in1Real,
    input wire detPkg::sample_t in1Imag,
    input wire detPkg::metric_t accMetricIn,
    output logic setupDone,
    output logic metricOutEn,
    output logic startNextStage,
    output logic bestValid,
    output detPkg::metric_t accMetricOut,
    output detPkg::metric_t bestMetric,
    output detPkg::pointIdx_t metricIndex,
    output detPkg::pointIdx_t bestIndex
);
    import detPkg::*;

    logic setupValid;
    sample_t setupReal;
    sample_t setupImag;

    metricStreamIf metStream ();

    setupGen u_setupGen (
        .clk(clk),
        .reset(reset),
        .clkEn(clkEn),
        .startFrame(startFrame),
        .gainReal(gainReal),
        .gainImag(gainImag),
        .setupValid(setupValid),
        .setupReal(setupReal),
        .setupImag(setupImag),
        .setupDone(setupDone)
    );

    acsStage1 #(
        .METRIC_LAT(METRIC_LAT)
    ) u_acsStage1 (
        .clk(clk),
        .reset(reset),
        .clkEn(clkEn),
        .startFrame(startFrame),
        .startBlock(startBlock),
        .startStage(startStage),
        .in1Real(in1Real),
        .in1Imag(in1Imag),
        .setupValid(setupValid),
        .setupReal(setupReal),
        .setupImag(setupImag),
        .accMetricInEn(accMetricInEn),
        .accMetricIn(accMetricIn),
        .metOut(metStream.source),
        .startNextStage(startNextStage)
    );

    survivorSelect u_survivorSelect (
        .clk(clk),
        .reset(reset),
        .metIn(metStream.sink),
        .bestValid(bestValid),
        .bestMetric(bestMetric),
        .bestIndex(bestIndex)
    );

    // metric stream also leaves the top for the next stage.
    assign metricOutEn = metStream.valid;
    assign accMetricOut = metStream.metric;
    assign metricIndex = metStream.index;

endmodule

`default_nettype wire

/* hw/metricStreamIf.sv */
`timescale 1ns/100ps
`default_nettype none

interface metricStreamIf;
    import detPkg::*;

    logic valid;       // one beat per hypothesis.
    metric_t metric;
    pointIdx_t index;
    logic last;        // set with index 15.

    modport source (
        output valid,
        output metric,
        output index,
        output last
    );

    modport sink (
        input valid,
        input metric,
        input index,
        input last
    );

endinterface

`default_nettype wire

/* hw/setupGen.sv */
`timescale 1ns/100ps
`default_nettype none

module setupGen (
    input wire logic clk,
    input wire logic reset,
    input wire logic clkEn,
    input wire logic startFrame,
    input wire detPkg::sample_t gainReal,
    input wire detPkg::sample_t gainImag,
    output logic setupValid,
    output detPkg::sample_t setupReal,
    output detPkg::sample_t setupImag,
    output logic setupDone
);
    import detPkg::*;

    typedef enum logic [1:0] {stIdle, stRun, stDone} genState_t;

    genState_t state;
    pointIdx_t pointCnt;
    logic restart;
    logic signed [2:0] levelRe;
    logic signed [2:0] levelIm;
    logic signed [20:0] prodRR;
    logic signed [20:0] prodII;
    logic signed [20:0] prodRI;
    logic signed [20:0] prodIR;
    logic signed [21:0] sumRe;
    logic signed [21:0] sumIm;
    logic prodValid;
    logic prodLast;
    logic setupLast;

    function automatic sample_t satSample(input logic signed [21:0] x);
        sample_t y;
        if (x[21:17] != {5{x[21]}}) begin
            y = x[21] ? 18'sh20000 : 18'sh1ffff;
        end else begin
            y = x[17:0];
        end
        return y;
    endfunction

    assign restart = clkEn && startFrame;
    assign levelRe = qamLevel(pointCnt[3:2]);
    assign levelIm = qamLevel(pointCnt[1:0]);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stIdle;
            pointCnt <= '0;
        end else if (restart) begin
            state <= stRun;
            pointCnt <= '0;
        end else if (state == stRun) begin
            pointCnt <= pointCnt + 1'b1;
            if (pointCnt == pointIdx_t'(NUM_POINTS - 1)) begin
                state <= stDone;
            end
        end
    end

    // gain times level pair, one point per cycle.
    always_ff @(posedge clk) begin
        prodRR <= gainReal * levelRe;
        prodII <= gainImag * levelIm;
        prodRI <= gainReal * levelIm;
        prodIR <= gainImag * levelRe;
    end

    assign sumRe = prodRR - prodII;
    assign sumIm = prodRI + prodIR;

    always_ff @(posedge clk) begin
        setupReal <= satSample(sumRe);
        setupImag <= satSample(sumIm);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prodValid <= 1'b0;
            prodLast <= 1'b0;
            setupValid <= 1'b0;
            setupLast <= 1'b0;
            setupDone <= 1'b0;
        end else begin
            prodValid <= (state == stRun) && !restart;
            prodLast <= (state == stRun) && !restart &&
                        (pointCnt == pointIdx_t'(NUM_POINTS - 1));
            setupValid <= prodValid && !restart;   // a restart drops entries in flight.
            setupLast <= prodLast && !restart;
            if (restart) begin
                setupDone <= 1'b0;
            end else if (setupValid && setupLast) begin
                setupDone <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/survivorSelect.sv */
`timescale 1ns/100ps
`default_nettype none

module survivorSelect (
    input wire logic clk,
    input wire logic reset,
    metricStreamIf.sink metIn,
    output logic bestValid,
    output detPkg::metric_t bestMetric,
    output detPkg::pointIdx_t bestIndex
);
    import detPkg::*;

    metric_t runMetric;
    pointIdx_t runIndex;
    logic takeNew;
    metric_t winMetric;
    pointIdx_t winIndex;

    // strict compare keeps the lower index on a tie.
    assign takeNew = (metIn.index == '0) || (metIn.metric < runMetric);
    assign winMetric = takeNew ? metIn.metric : runMetric;
    assign winIndex = takeNew ? metIn.index : runIndex;

    always_ff @(posedge clk) begin
        if (metIn.valid) begin
            runMetric <= winMetric;
            runIndex <= winIndex;
        end
    end

    always_ff @(posedge clk) begin
        if (metIn.valid && metIn.last) begin
            bestMetric <= winMetric;   // includes the last beat itself.
            bestIndex <= winIndex;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bestValid <= 1'b0;
        end else begin
            bestValid <= metIn.valid && metIn.last;
        end
    end

endmodule

`default_nettype wire

/* sim/detStage1Tb.sv */
`timescale 1ns/100ps
`default_nettype none

module detStage1Tb;
    import detPkg::*;

    localparam int METRIC_LAT = 2;
    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 4;
    localparam int SETUP_CYCLES = NUM_POINTS + 2;   // entry 15 at 17, done one cycle later.
    localparam int MAX_GAP = 3;
    localparam int NUM_FRAMES = 6;
    localparam int NUM_BLOCKS = 9;
    localparam int FRAME_CYCLES = SETUP_CYCLES + 4;
    localparam int BLOCK_CYCLES = NUM_POINTS * (MAX_GAP + 1) + METRIC_LAT + 8;
    localparam int WATCHDOG_NS = (RESET_CYCLES + NUM_FRAMES * FRAME_CYCLES +
                                  NUM_BLOCKS * BLOCK_CYCLES + 100) * CLK_PERIOD;
    localparam logic [31:0] LCG_SEED = 32'h11e21dcd;
    localparam longint SAMPLE_MAX = 131071;
    localparam longint SAMPLE_MIN = -131072;
    localparam longint METRIC_MAX = 262143;

    logic clk;
    logic reset;
    logic clkEn;
    logic startFrame;
    logic startBlock;
    logic startStage;
    logic accMetricInEn;
    sample_t gainReal;
    sample_t gainImag;
    sample_t in1Real;
    sample_t in1Imag;
    metric_t accMetricIn;
    logic setupDone;
    logic metricOutEn;
    logic startNextStage;
    logic bestValid;
    metric_t accMetricOut;
    metric_t bestMetric;
    pointIdx_t metricIndex;
    pointIdx_t bestIndex;

    logic [31:0] lcgState;
    bit verdictPrinted = 1'b0;
    longint tableRe [NUM_POINTS];   // model of the point table.
    longint tableIm [NUM_POINTS];
    longint curRe;
    longint curIm;
    metric_t blockAcc [NUM_POINTS];
    metric_t gotMetricQ [$];
    pointIdx_t gotIndexQ [$];
    metric_t gotBestMetricQ [$];
    pointIdx_t gotBestIndexQ [$];

    detStage1Top #(
        .METRIC_LAT(METRIC_LAT)
    ) u_detStage1Top (
        .clk(clk),
        .reset(reset),
        .clkEn(clkEn),
        .startFrame(startFrame),
        .startBlock(startBlock),
        .startStage(startStage),
        .accMetricInEn(accMetricInEn),
        .gainReal(gainReal),
        .gainImag(gainImag),
        .in1Real(in1Real),
        .in1Imag(in1Imag),
        .accMetricIn(accMetricIn),
        .setupDone(setupDone),
        .metricOutEn(metricOutEn),
        .startNextStage(startNextStage),
        .bestValid(bestValid),
        .accMetricOut(accMetricOut),
        .bestMetric(bestMetric),
        .metricIndex(metricIndex),
        .bestIndex(bestIndex)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        verdictPrinted = 1'b1;
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    // collect the stream and the survivor as they leave the top.
    always @(negedge clk) begin
        if (metricOutEn) begin
            gotMetricQ.push_back(accMetricOut);
            gotIndexQ.push_back(metricIndex);
        end
        if (bestValid) begin
            gotBestMetricQ.push_back(bestMetric);
            gotBestIndexQ.push_back(bestIndex);
        end
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic sample_t randSample(input int bits);
        logic [31:0] r;
        r = nextRand();
        return sample_t'($signed(r) >>> (32 - bits));   // upper bits, sign kept.
    endfunction

    function automatic longint levelOf(input int code);
        return 2 * code - 3;
    endfunction

    function automatic longint clampSample(input longint x);
        if (x > SAMPLE_MAX) begin
            return SAMPLE_MAX;
        end
        if (x < SAMPLE_MIN) begin
            return SAMPLE_MIN;
        end
        return x;
    endfunction

    function automatic metric_t modelMetric(input int k, input metric_t acc,
                                            input longint yr, input longint yi);
        longint dr;
        longint di;
        longint sum;
        dr = tableRe[k] - yr;
        di = tableIm[k] - yi;
        sum = longint'(acc) + ((dr * dr + di * di) >> DIST_SHIFT);
        if (sum > METRIC_MAX) begin
            sum = METRIC_MAX;
        end
        return metric_t'(sum);
    endfunction

    task automatic buildTable(input sample_t gr, input sample_t gi);
        longint lr;
        longint li;
        for (int k = 0; k < NUM_POINTS; k++) begin
            lr = levelOf(k / 4);
            li = levelOf(k % 4);
            tableRe[k] = clampSample(longint'(gr) * lr - longint'(gi) * li);
            tableIm[k] = clampSample(longint'(gr) * li + longint'(gi) * lr);
        end
    endtask

    task automatic failRun();
        verdictPrinted = 1'b1;
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkMetric(input string name, input metric_t got, input metric_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp);
            failRun();
        end
    endtask

    task automatic checkIndex(input string name, input pointIdx_t got, input pointIdx_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp);
            failRun();
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
            failRun();
        end
    endtask

    task automatic tick(input logic expNext);
        @(negedge clk);
        checkFlag("startNextStage", startNextStage, expNext);
    endtask

    task automatic loadFrame(input sample_t gr, input sample_t gi);
        gainReal = gr;
        gainImag = gi;
        startFrame = 1'b1;
        buildTable(gr, gi);
        for (int c = 0; c <= SETUP_CYCLES; c++) begin
            @(negedge clk);
            startFrame = 1'b0;
            checkFlag("setupDone", setupDone, c == SETUP_CYCLES);
        end
    endtask

    task automatic runBlock(input logic capture, input sample_t sr, input sample_t si,
                            input int maxGap);
        metric_t expM [NUM_POINTS];
        int bestK;
        int gap;
        logic [31:0] r;
        if (capture) begin
            curRe = longint'(sr);
            curIm = longint'(si);
        end
        bestK = 0;
        for (int k = 0; k < NUM_POINTS; k++) begin
            expM[k] = modelMetric(k, blockAcc[k], curRe, curIm);
            if (expM[k] < expM[bestK]) begin
                bestK = k;   // strict, so the lower index keeps a tie.
            end
        end
        startStage = 1'b1;
        startBlock = capture;
        in1Real = sr;
        in1Imag = si;
        tick(1'b0);
        startStage = 1'b0;
        startBlock = 1'b0;
        for (int k = 0; k < NUM_POINTS; k++) begin
            r = nextRand();
            gap = int'(r % 32'(maxGap + 1));
            repeat (gap) tick(1'b0);
            accMetricInEn = 1'b1;
            accMetricIn = blockAcc[k];
            tick(k == 1);
            accMetricInEn = 1'b0;
        end
        tick(1'b0);
        while (gotMetricQ.size() < NUM_POINTS || gotBestMetricQ.size() < 1) begin
            @(negedge clk);
        end
        for (int k = 0; k < NUM_POINTS; k++) begin
            checkMetric("accMetricOut", gotMetricQ.pop_front(), expM[k]);
            checkIndex("metricIndex", gotIndexQ.pop_front(), pointIdx_t'(k));
        end
        checkMetric("bestMetric", gotBestMetricQ.pop_front(), expM[bestK]);
        checkIndex("bestIndex", gotBestIndexQ.pop_front(), pointIdx_t'(bestK));
    endtask

    task automatic randomAcc();
        for (int k = 0; k < NUM_POINTS; k++) begin
            blockAcc[k] = metric_t'(nextRand() >> 16);
        end
    endtask

    task automatic testDistanceOnly();
        loadFrame(18'sd4096, 18'sd0);
        for (int k = 0; k < NUM_POINTS; k++) begin
            blockAcc[k] = '0;
        end
        runBlock(1'b1, 18'sd0, 18'sd0, 0);
    endtask

    task automatic testAccumulation();
        loadFrame(randSample(15), randSample(15));
        for (int b = 0; b < 3; b++) begin
            randomAcc();
            runBlock(1'b1, randSample(16), randSample(16), MAX_GAP);
        end
    endtask

    task automatic testSaturation();
        loadFrame(18'sd30000, 18'sd30000);
        for (int k = 0; k < NUM_POINTS; k++) begin
            blockAcc[k] = 18'h3ffff - 18'(k);   // just below the top.
        end
        runBlock(1'b1, 18'sh20000, 18'sh20000, 1);
    endtask

    task automatic testSurvivorTie();
        metric_t d5;
        metric_t d9;
        metric_t tieSum;
        loadFrame(18'sd4096, -18'sd2048);
        randomAcc();
        runBlock(1'b1, randSample(14), randSample(14), MAX_GAP);
        d5 = modelMetric(5, '0, 1000, -2000);
        d9 = modelMetric(9, '0, 1000, -2000);
        tieSum = ((d5 > d9) ? d5 : d9) + 18'd10;
        for (int k = 0; k < NUM_POINTS; k++) begin
            blockAcc[k] = tieSum + 18'd100;
        end
        blockAcc[5] = tieSum - d5;   // 5 and 9 land on the same sum.
        blockAcc[9] = tieSum - d9;
        runBlock(1'b1, 18'sd1000, -18'sd2000, 2);
    endtask

    task automatic testNewFrame();
        clkEn = 1'b0;
        gainReal = 18'sd8192;
        gainImag = 18'sd4096;
        startFrame = 1'b1;
        startBlock = 1'b1;
        in1Real = 18'sd5000;
        in1Imag = -18'sd7000;
        @(negedge clk);
        startFrame = 1'b0;
        startBlock = 1'b0;
        repeat (SETUP_CYCLES) begin
            @(negedge clk);
            checkFlag("setupDone", setupDone, 1'b1);
        end
        clkEn = 1'b1;
        randomAcc();
        runBlock(1'b0, 18'sd0, 18'sd0, 1);   // old table and old sample.
        loadFrame(18'sd8192, 18'sd4096);
        randomAcc();
        runBlock(1'b1, randSample(16), randSample(16), MAX_GAP);
    endtask

    initial begin
        reset = 1'b1;
        clkEn = 1'b1;
        startFrame = 1'b0;
        startBlock = 1'b0;
        startStage = 1'b0;
        accMetricInEn = 1'b0;
        gainReal = '0;
        gainImag = '0;
        in1Real = '0;
        in1Imag = '0;
        accMetricIn = '0;
        lcgState = LCG_SEED;
        curRe = 0;
        curIm = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        testDistanceOnly();
        testAccumulation();
        testSaturation();
        testSurvivorTie();
        testNewFrame();
        repeat (METRIC_LAT + 4) @(negedge clk);
        if (gotMetricQ.size() == 0 && gotBestMetricQ.size() == 0) begin
            verdictPrinted = 1'b1;
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("metric or survivor outputs appeared after the last block");
            failRun();
        end
    end

    final begin
        if (!verdictPrinted) begin
            $display("the run stopped before the tests completed");
            $display("CHECKS FAILED");
        end
    end

endmodule

`default_nettype wire

/* sim/detStage1_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module detStage1_assert #(
    parameter int METRIC_LAT = 2
) (
    input wire logic clk,
    input wire logic reset,
    input wire logic accMetricInEn,
    input wire logic metricOutEn,
    input wire detPkg::pointIdx_t metricIndex,
    input wire logic startNextStage,
    input wire logic bestValid,
    input wire logic setupDone
);
    import detPkg::*;

    // output beat trails the input enable by the pipeline depth.
    latencyCheck: assert property (@(posedge clk) disable iff (reset)
        metricOutEn == $past(accMetricInEn, METRIC_LAT))
        else $error("metricOutEn does not follow accMetricInEn by %0d cycles", METRIC_LAT);

    // a lone pulse right after an accepted metric.
    nextStagePulse: assert property (@(posedge clk) disable iff (reset)
        startNextStage |-> $past(accMetricInEn) && !$past(startNextStage))
        else $error("startNextStage is not a single pulse after an accepted metric");

    // survivor strobe one cycle after the beat with index 15.
    bestPulse: assert property (@(posedge clk) disable iff (reset)
        bestValid == $past(metricOutEn && (metricIndex == pointIdx_t'(NUM_POINTS - 1))))
        else $error("bestValid is not a single pulse one cycle after the last beat");

    // flops settle low one edge into reset.
    resetQuiet: assert property (@(posedge clk)
        reset |=> !(metricOutEn || startNextStage || bestValid || setupDone))
        else $error("strobe high during reset");

endmodule

bind detStage1Top detStage1_assert #(
    .METRIC_LAT(METRIC_LAT)
) u_detStage1Assert (
    .clk(clk),
    .reset(reset),
    .accMetricInEn(accMetricInEn),
    .metricOutEn(metricOutEn),
    .metricIndex(metricIndex),
    .startNextStage(startNextStage),
    .bestValid(bestValid),
    .setupDone(setupDone)
);

`default_nettype wire
